// File: bench/falling_spikes_obstacle_properties.sv
`timescale 1ns/1ps

`include "spike_defs.svh"

module falling_spikes_obstacle_properties import spike_pkg::*; (
    input logic       clk,
    input logic       rst,
    input coord_t     hcount,
    input coord_t     vcount,
    input rgb_t       rgb_in,
    input logic       menu_on,
    input logic       play_selected,
    input logic       done_in,
    input logic [3:0] selected,
    input coord_t     mouse_xpos,
    input rgb_t       rgb_out,
    input coord_t     obstacle_x,
    input coord_t     obstacle_y,
    input logic       done
);

    // last row of the aim zone at each edge
    localparam coord_t AIM_TOP_END   = coord_t'(`FIELD_TOP + `SPIKE_DEPTH);
    localparam coord_t AIM_BOT_START = coord_t'(`FIELD_BOTTOM - `SPIKE_DEPTH);

    int     errors = 0;
    logic   start;
    logic   hit;
    logic   run;
    logic   run_q;
    logic   rst_q;
    rgb_t   rgb_in_q;
    coord_t hcount_q;
    coord_t vcount_q;
    coord_t col_dist;

    ////////////////////
    // reference model
    ////////////////////

    // handover from the game when the previous obstacle is done and play is active
    assign start = done_in && (selected == `OBSTACLE_ID) && play_selected;
    assign hit   = (obstacle_x != '0) || (obstacle_y != '0);

    always_comb begin
        if (obstacle_x >= mouse_xpos) begin
            col_dist = obstacle_x - mouse_xpos;
        end else begin
            col_dist = mouse_xpos - obstacle_x;
        end
    end

    // run is open from a valid start until done or an abort
    always_ff @(posedge clk) begin
        if (rst) begin
            run <= 1'b0;
        end else if (!run && start) begin
            run <= 1'b1;
        end else if (done || menu_on || !play_selected) begin
            run <= 1'b0;
        end
        run_q    <= run;
        rst_q    <= rst;
        rgb_in_q <= rgb_in;
        hcount_q <= hcount;
        vcount_q <= vcount;
    end

    ////////////////////
    // pixel path
    ////////////////////

    reset_clear: assert property (@(posedge clk)
        rst_q |-> (rgb_out == '0) && !hit && !done)
        else begin
            errors++;
            $error("Error at %0t: rgb_out=%h obstacle_x=%h obstacle_y=%h done=%b, expected 0",
                $time, $sampled(rgb_out), $sampled(obstacle_x), $sampled(obstacle_y),
                $sampled(done));
        end

    // no collision means the background goes through untouched
    miss_passes_rgb: assert property (@(posedge clk) disable iff (rst)
        !rst_q && !hit |-> rgb_out == rgb_in_q)
        else begin
            errors++;
            $error("Error at %0t: rgb_out is %h, expected %h",
                $time, $sampled(rgb_out), $sampled(rgb_in_q));
        end

    hit_matches_pixel: assert property (@(posedge clk) disable iff (rst)
        !rst_q && hit |-> (obstacle_x == hcount_q) && (obstacle_y == vcount_q))
        else begin
            errors++;
            $error("Error at %0t: obstacle_x/obstacle_y is %0d/%0d, expected %0d/%0d",
                $time, $sampled(obstacle_x), $sampled(obstacle_y), $sampled(hcount_q),
                $sampled(vcount_q));
        end

    hit_color: assert property (@(posedge clk) disable iff (rst)
        hit |-> (rgb_out == rgb_t'(`COLOR_WHITE)) || (rgb_out == rgb_t'(`COLOR_RED)))
        else begin
            errors++;
            $error("Error at %0t: rgb_out is %h on a hit, expected %h or %h",
                $time, $sampled(rgb_out), rgb_t'(`COLOR_WHITE), rgb_t'(`COLOR_RED));
        end

    ////////////////////
    // run control
    ////////////////////

    // one cycle of slack for the pixel already in the output register
    hits_only_in_run: assert property (@(posedge clk) disable iff (rst)
        hit |-> run || run_q)
        else begin
            errors++;
            $error("Error at %0t: collision point %0d/%0d appeared with no run open",
                $time, $sampled(obstacle_x), $sampled(obstacle_y));
        end

    // the spike is already off screen while done is high
    no_hit_after_done: assert property (@(posedge clk) disable iff (rst)
        done |=> !hit)
        else begin
            errors++;
            $error("Error at %0t: collision point %0d/%0d appeared after done",
                $time, $sampled(obstacle_x), $sampled(obstacle_y));
        end

    done_only_in_run: assert property (@(posedge clk) disable iff (rst)
        done |-> run)
        else begin
            errors++;
            $error("Error at %0t: done is 1, expected 0 outside a started run", $time);
        end

    done_one_cycle: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
        else begin
            errors++;
            $error("Error at %0t: done is 1, expected 0 after a one cycle pulse", $time);
        end

    ////////////////////
    // spike geometry
    ////////////////////

    // red only while aiming, so the base still sits on an edge
    red_near_edge: assert property (@(posedge clk) disable iff (rst)
        hit && (rgb_out == rgb_t'(`COLOR_RED)) |->
            (obstacle_y <= AIM_TOP_END) || (obstacle_y >= AIM_BOT_START))
        else begin
            errors++;
            $error("Error at %0t: red hit at obstacle_y %0d, expected a row within %0d of an edge",
                $time, $sampled(obstacle_y), `SPIKE_DEPTH);
        end

    // rows between the aim zones are only reached while falling under the mouse
    middle_under_mouse: assert property (@(posedge clk) disable iff (rst)
        hit && (obstacle_y > AIM_TOP_END) && (obstacle_y < AIM_BOT_START) |->
            col_dist <= coord_t'(`SPIKE_HALF_WIDTH))
        else begin
            errors++;
            $error("Error at %0t: obstacle_x is %0d, expected within %0d of mouse column %0d",
                $time, $sampled(obstacle_x), `SPIKE_HALF_WIDTH, $sampled(mouse_xpos));
        end

endmodule

// File: bench/falling_spikes_obstacle_tb.sv
`timescale 1ns/1ps

`include "spike_defs.svh"

module falling_spikes_obstacle_tb import spike_pkg::*; ();

    localparam int AIM_TICKS    = 400;
    localparam int SLOW_STEP    = 3;
    localparam int FAST_STEP    = 1;
    localparam int SETTLE_TICKS = 30;
    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 2;
    // keep the mouse inside the AIM_TICKS/SLOW_STEP columns a slow aim covers
    localparam int MOUSE_RANGE  = AIM_TICKS / SLOW_STEP - 10;
    localparam int FIELD_SPAN   = `FIELD_BOTTOM - `FIELD_TOP;
    // slow fall across the whole field plus aim, settle and some slack
    localparam int WORST_ATTACK = AIM_TICKS + SLOW_STEP * (FIELD_SPAN + 2) + SETTLE_TICKS + 8;
    localparam int IDLE_CYCLES  = 600;
    localparam int ABORT_AFTER  = 1500;
    localparam int TEST_CYCLES  = `ATTACK_COUNT * WORST_ATTACK + ABORT_AFTER + 5 * IDLE_CYCLES;
    localparam int TIMEOUT_NS   = (TEST_CYCLES + 200) * CLK_PERIOD;

    logic       clk;
    logic       rst;
    coord_t     hcount;
    coord_t     vcount;
    rgb_t       rgb_in;
    logic       game_on;
    logic       menu_on;
    logic       play_selected;
    logic       done_in;
    logic [3:0] selected;
    coord_t     mouse_xpos;
    rgb_t       rgb_out;
    coord_t     obstacle_x;
    coord_t     obstacle_y;
    logic       done;
    int         seed = 72104;

    tb_clock #(.PERIOD_NS(CLK_PERIOD)) clock_i (.clk(clk));

    falling_spikes_obstacle #(
        .AIM_TICKS    (AIM_TICKS),
        .SLOW_STEP    (SLOW_STEP),
        .FAST_STEP    (FAST_STEP),
        .SETTLE_TICKS (SETTLE_TICKS)
    ) dut_i (
        .clk           (clk),
        .rst           (rst),
        .hcount        (hcount),
        .vcount        (vcount),
        .rgb_in        (rgb_in),
        .game_on       (game_on),
        .menu_on       (menu_on),
        .play_selected (play_selected),
        .done_in       (done_in),
        .selected      (selected),
        .mouse_xpos    (mouse_xpos),
        .rgb_out       (rgb_out),
        .obstacle_x    (obstacle_x),
        .obstacle_y    (obstacle_y),
        .done          (done)
    );

    bind falling_spikes_obstacle falling_spikes_obstacle_properties props_i (
        .clk           (clk),
        .rst           (rst),
        .hcount        (hcount),
        .vcount        (vcount),
        .rgb_in        (rgb_in),
        .menu_on       (menu_on),
        .play_selected (play_selected),
        .done_in       (done_in),
        .selected      (selected),
        .mouse_xpos    (mouse_xpos),
        .rgb_out       (rgb_out),
        .obstacle_x    (obstacle_x),
        .obstacle_y    (obstacle_y),
        .done          (done)
    );

    ////////////////////
    // helpers
    ////////////////////

    // n rising edges, then the drive delay
    task automatic step_cycles(input int n);
        repeat (n) @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // one cycle done_in pulse from the previous obstacle
    task automatic hand_over(input logic [3:0] sel);
        selected = sel;
        done_in  = 1'b1;
        step_cycles(1);
        done_in  = 1'b0;
    endtask

    // watchdog catches a done that never comes
    task automatic wait_for_done();
        @(negedge clk);
        while (!done) begin
            @(negedge clk);
        end
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    // random pixel inside the field every cycle
    always begin
        @(posedge clk);
        #DRIVE_DELAY;
        hcount = coord_t'(`SPIKE_START_X - 150 + ($unsigned($random(seed)) % (FIELD_SPAN + 1)));
        vcount = coord_t'(`FIELD_TOP + ($unsigned($random(seed)) % (FIELD_SPAN + 1)));
        rgb_in = rgb_t'($random(seed));
    end

    initial begin
        rst           = 1'b1;
        hcount        = coord_t'(`FIELD_TOP);
        vcount        = coord_t'(`FIELD_TOP);
        rgb_in        = '0;
        game_on       = 1'b1;
        menu_on       = 1'b0;
        play_selected = 1'b1;
        done_in       = 1'b0;
        selected      = 4'd3;
        // mouse stays put for the whole test
        mouse_xpos = coord_t'(`SPIKE_START_X - MOUSE_RANGE
            + ($unsigned($random(seed)) % (2 * MOUSE_RANGE + 1)));
        step_cycles(2);
        rst = 1'b0;
        step_cycles(IDLE_CYCLES);

        // handover for another obstacle id must not start a run
        hand_over(4'd3);
        step_cycles(IDLE_CYCLES);

        // full run of all attacks
        hand_over(`OBSTACLE_ID);
        wait_for_done();
        step_cycles(IDLE_CYCLES);

        // second run with play dropped while the second attack aims
        hand_over(`OBSTACLE_ID);
        step_cycles(ABORT_AFTER);
        play_selected = 1'b0;
        step_cycles(IDLE_CYCLES);
        play_selected = 1'b1;
        step_cycles(IDLE_CYCLES);

        if (dut_i.props_i.errors == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("TESTS FAILED");
            $fatal(1, "property checks reported %0d failures", dut_i.props_i.errors);
        end
    end

    ////////////////////
    // failure and timeout
    ////////////////////

    // stop at the first failed property
    always @(negedge clk) begin
        if (dut_i.props_i.errors != 0) begin
            $display("TESTS FAILED");
            $fatal(1, "a property check failed at %0t, see the error above", $time);
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired at %0t before the test sequence finished", $time);
    end

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    // free running, first rising edge at half a period
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

// File: falling_spikes_obstacle.f
+incdir+hw
hw/spike_pkg.sv
hw/spike_sequencer.sv
hw/spike_timer.sv
hw/spike_mover.sv
hw/spike_raster.sv
hw/falling_spikes_obstacle.sv
bench/tb_clock.sv
bench/falling_spikes_obstacle_properties.sv
bench/falling_spikes_obstacle_tb.sv

// File: hw/falling_spikes_obstacle.sv
`timescale 1ns/1ps

`include "spike_defs.svh"

module falling_spikes_obstacle import spike_pkg::*; #(
    parameter int AIM_TICKS    = `DEF_AIM_TICKS,
    parameter int SLOW_STEP    = `DEF_SLOW_STEP,
    parameter int FAST_STEP    = `DEF_FAST_STEP,
    parameter int SETTLE_TICKS = `DEF_SETTLE_TICKS
) (
    input  logic       clk,
    input  logic       rst,
    input  coord_t     hcount,
    input  coord_t     vcount,
    input  rgb_t       rgb_in,
    // game_on comes from the game top and is not needed here
    input  logic       game_on,
    input  logic       menu_on,
    input  logic       play_selected,
    input  logic       done_in,
    input  logic [3:0] selected,
    input  coord_t     mouse_xpos,
    output rgb_t       rgb_out,
    output coord_t     obstacle_x,
    output coord_t     obstacle_y,
    output logic       done
);

    phase_t  phase;
    attack_t attack;
    spike_t  spike;
    pixel_t  pixel;
    pixel_t  hit_pixel;
    logic    load;
    logic    start_ok;
    logic    abort;
    logic    aim_over;
    logic    settle_over;
    logic    step_tick;
    logic    at_edge;
    logic    visible;

    ////////////////////
    // game handover
    ////////////////////

    // previous obstacle finished, this one is next and play is active
    assign start_ok = done_in && (selected == `OBSTACLE_ID) && play_selected;
    assign abort    = menu_on || !play_selected;
    // spike is on screen for the whole attack
    assign visible  = (phase == AIM) || (phase == FALL) || (phase == SETTLE);
    assign pixel    = '{x: hcount, y: vcount};

    spike_sequencer sequencer_i (
        .clk         (clk),
        .rst         (rst),
        .start_ok    (start_ok),
        .abort       (abort),
        .aim_over    (aim_over),
        .at_edge     (at_edge),
        .settle_over (settle_over),
        .phase       (phase),
        .attack      (attack),
        .load        (load),
        .done        (done)
    );

    spike_timer #(
        .AIM_TICKS    (AIM_TICKS),
        .SLOW_STEP    (SLOW_STEP),
        .FAST_STEP    (FAST_STEP),
        .SETTLE_TICKS (SETTLE_TICKS)
    ) timer_i (
        .clk         (clk),
        .rst         (rst),
        .phase       (phase),
        .barrage     (attack.barrage),
        .step_tick   (step_tick),
        .aim_over    (aim_over),
        .settle_over (settle_over)
    );

    spike_mover mover_i (
        .clk        (clk),
        .rst        (rst),
        .phase      (phase),
        .attack     (attack),
        .load       (load),
        .step_tick  (step_tick),
        .mouse_xpos (mouse_xpos),
        .spike      (spike),
        .at_edge    (at_edge)
    );

    spike_raster raster_i (
        .clk       (clk),
        .rst       (rst),
        .spike     (spike),
        .visible   (visible),
        .pixel     (pixel),
        .rgb_in    (rgb_in),
        .rgb_out   (rgb_out),
        .hit_pixel (hit_pixel)
    );

    // collision point for the game's hit detection
    assign obstacle_x = hit_pixel.x;
    assign obstacle_y = hit_pixel.y;

endmodule

// File: hw/spike_defs.svh
`ifndef SPIKE_DEFS_SVH
`define SPIKE_DEFS_SVH

////////////////////
// game field
////////////////////

// vertical edges of the 300 x 300 play area
`define FIELD_TOP           317
`define FIELD_BOTTOM        617

////////////////////
// spike geometry
////////////////////

// center column every attack starts from
`define SPIKE_START_X       511
// half of the base width, also the stop margin at the far edge
`define SPIKE_HALF_WIDTH    20
// base to tip distance in rows
`define SPIKE_DEPTH         50
// 3*|dx| + dy bound for the slanted sides
`define SPIKE_REACH         60

////////////////////
// colors and ids
////////////////////

`define COLOR_WHITE         12'hfff
`define COLOR_RED           12'hf00
// obstacle number in the game's selection order
`define OBSTACLE_ID         4'd5
`define ATTACK_COUNT        20

// default tick counts at 65 MHz
// aim time 1 s
`define DEF_AIM_TICKS       65000000
`define DEF_SLOW_STEP       300000
`define DEF_FAST_STEP       150000
// settle time 0.5 s
`define DEF_SETTLE_TICKS    32500000

`endif

// File: hw/spike_mover.sv
`timescale 1ns/1ps

`include "spike_defs.svh"

module spike_mover import spike_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  phase_t  phase,
    input  attack_t attack,
    input  logic    load,
    input  logic    step_tick,
    input  coord_t  mouse_xpos,
    output spike_t  spike,
    output logic    at_edge
);

    localparam coord_t START_X   = coord_t'(`SPIKE_START_X);
    localparam coord_t EDGE_TOP  = coord_t'(`FIELD_TOP);
    localparam coord_t EDGE_BOT  = coord_t'(`FIELD_BOTTOM);
    // stop rows for the base, one margin short of the far edge
    localparam coord_t STOP_TOP  = coord_t'(`FIELD_TOP + `SPIKE_HALF_WIDTH);
    localparam coord_t STOP_BOT  = coord_t'(`FIELD_BOTTOM - `SPIKE_HALF_WIDTH);

    coord_t center_x;
    coord_t base_y;
    logic   aim_step;
    logic   fall_step;

    // far edge depends on direction
    assign at_edge = attack.from_bottom ? (base_y <= STOP_TOP) : (base_y >= STOP_BOT);

    assign aim_step  = step_tick && (phase == AIM);
    // once the margin is reached the spike just stays there
    assign fall_step = step_tick && (phase == FALL) && !at_edge;

    ////////////////////
    // position
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            center_x <= START_X;
            base_y   <= EDGE_TOP;
        end else if (load) begin
            center_x <= START_X;
            base_y   <= attack.from_bottom ? EDGE_BOT : EDGE_TOP;
        end else if (aim_step) begin
            // follow the mouse one column at a time, hold when lined up
            if (center_x < mouse_xpos) begin
                center_x <= center_x + coord_t'(1);
            end else if (center_x > mouse_xpos) begin
                center_x <= center_x - coord_t'(1);
            end
        end else if (fall_step) begin
            if (attack.from_bottom) begin
                base_y <= base_y - coord_t'(1);
            end else begin
                base_y <= base_y + coord_t'(1);
            end
        end
    end

    // red marks a barrage while it is still aiming
    assign spike = '{
        center_x:    center_x,
        base_y:      base_y,
        from_bottom: attack.from_bottom,
        red:         (phase == AIM) && attack.barrage
    };

endmodule

// File: hw/spike_pkg.sv
package spike_pkg;

    ////////////////////
    // basic scalars
    ////////////////////

    // screen coordinate, same width as the vga counters
    typedef logic [11:0] coord_t;

    // 4 bits per channel
    typedef logic [11:0] rgb_t;

    ////////////////////
    // grouped signals
    ////////////////////

    // one raster position
    typedef struct packed {
        coord_t x;
        coord_t y;
    } pixel_t;

    // kind of attack taken from the schedule
    typedef struct packed {
        // base sits on the bottom edge, spike points up
        logic from_bottom;
        // fast stepping, drawn red while aiming
        logic barrage;
    } attack_t;

    // sequencer states
    typedef enum logic [2:0] {
        IDLE,
        DISTRIBUTE,
        AIM,
        FALL,
        SETTLE
    } phase_t;

    // everything the raster needs to draw the spike
    typedef struct packed {
        coord_t center_x;
        coord_t base_y;
        logic   from_bottom;
        logic   red;
    } spike_t;

endpackage

// File: hw/spike_raster.sv
`timescale 1ns/1ps

`include "spike_defs.svh"

module spike_raster import spike_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  spike_t spike,
    input  logic   visible,
    input  pixel_t pixel,
    input  rgb_t   rgb_in,
    output rgb_t   rgb_out,
    output pixel_t hit_pixel
);

    // column and row distances from the spike center and base
    coord_t      dx;
    coord_t      dy;
    logic        in_rows;
    logic        in_cols;
    logic        in_depth;
    logic        in_reach;
    logic        hit;
    // 3*4095 + 4095 still fits in 14 bits
    logic [13:0] reach_sum;

    ////////////////////
    // triangle test
    ////////////////////

    always_comb begin
        if (pixel.x >= spike.center_x) begin
            dx = pixel.x - spike.center_x;
        end else begin
            dx = spike.center_x - pixel.x;
        end
        // dy counts from the base toward the tip
        if (spike.from_bottom) begin
            in_rows = pixel.y <= spike.base_y;
            dy      = spike.base_y - pixel.y;
        end else begin
            in_rows = pixel.y >= spike.base_y;
            dy      = pixel.y - spike.base_y;
        end
    end

    assign in_cols   = dx <= coord_t'(`SPIKE_HALF_WIDTH);
    assign in_depth  = dy <= coord_t'(`SPIKE_DEPTH);
    // slope of 3 rows per column on both sides
    assign reach_sum = 14'(dx) * 14'd3 + 14'(dy);
    assign in_reach  = reach_sum <= 14'(`SPIKE_REACH);

    assign hit = visible && in_rows && in_cols && in_depth && in_reach;

    ////////////////////
    // output stage
    ////////////////////

    // one register stage, the pixel and its color leave together
    always_ff @(posedge clk) begin
        if (rst) begin
            rgb_out   <= '0;
            hit_pixel <= '0;
        end else if (hit) begin
            rgb_out   <= spike.red ? rgb_t'(`COLOR_RED) : rgb_t'(`COLOR_WHITE);
            hit_pixel <= pixel;
        end else begin
            // pass background through, no collision
            rgb_out   <= rgb_in;
            hit_pixel <= '0;
        end
    end

endmodule

// File: hw/spike_sequencer.sv
`timescale 1ns/1ps

`include "spike_defs.svh"

module spike_sequencer import spike_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    start_ok,
    input  logic    abort,
    input  logic    aim_over,
    input  logic    at_edge,
    input  logic    settle_over,
    output phase_t  phase,
    output attack_t attack,
    output logic    load,
    output logic    done
);

    // index of the attack being run, 0..20
    logic [4:0] attack_idx;
    logic [4:0] attack_idx_nxt;
    phase_t     phase_nxt;
    logic       all_done;
    logic       settle_needed;
    logic       running;

    ////////////////////
    // attack schedule
    ////////////////////

    // fixed table of 20 attacks
    // single from top is the all-zero entry (0, 4, 6, 12, 18)
    function automatic attack_t schedule(input logic [4:0] idx);
        attack_t a;
        case (idx)
            5'd3, 5'd8, 5'd9, 5'd14, 5'd16:
                a = '{from_bottom: 1'b0, barrage: 1'b1};
            5'd2, 5'd5, 5'd11, 5'd15, 5'd19:
                a = '{from_bottom: 1'b1, barrage: 1'b0};
            5'd1, 5'd7, 5'd10, 5'd13, 5'd17:
                a = '{from_bottom: 1'b1, barrage: 1'b1};
            default:
                a = '{from_bottom: 1'b0, barrage: 1'b0};
        endcase
        return a;
    endfunction

    // index stays put for the whole attack, so the decode is stable
    assign attack        = schedule(attack_idx);
    assign all_done      = attack_idx == 5'(`ATTACK_COUNT);
    // only slow spikes from the top pause after landing
    assign settle_needed = !attack.barrage && !attack.from_bottom;
    assign running       = (phase == AIM) || (phase == FALL) || (phase == SETTLE);

    // distribute lasts one cycle and either loads the next spike or finishes
    assign load = (phase == DISTRIBUTE) && !all_done;
    assign done = (phase == DISTRIBUTE) && all_done;

    ////////////////////
    // next state
    ////////////////////

    always_comb begin
        phase_nxt      = phase;
        attack_idx_nxt = attack_idx;
        case (phase)
            IDLE: begin
                if (start_ok) begin
                    phase_nxt      = DISTRIBUTE;
                    attack_idx_nxt = '0;
                end
            end
            DISTRIBUTE: begin
                phase_nxt = all_done ? IDLE : AIM;
            end
            AIM: begin
                if (aim_over) begin
                    phase_nxt = FALL;
                end
            end
            FALL: begin
                // base reached the far margin
                if (at_edge) begin
                    if (settle_needed) begin
                        phase_nxt = SETTLE;
                    end else begin
                        phase_nxt      = DISTRIBUTE;
                        attack_idx_nxt = attack_idx + 5'd1;
                    end
                end
            end
            SETTLE: begin
                if (settle_over) begin
                    phase_nxt      = DISTRIBUTE;
                    attack_idx_nxt = attack_idx + 5'd1;
                end
            end
            default: begin
                phase_nxt = IDLE;
            end
        endcase
        // menu or leaving play drops the run with no done pulse
        if (abort && running) begin
            phase_nxt = IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase      <= IDLE;
            attack_idx <= '0;
        end else begin
            phase      <= phase_nxt;
            attack_idx <= attack_idx_nxt;
        end
    end

endmodule

// File: hw/spike_timer.sv
`timescale 1ns/1ps

`include "spike_defs.svh"

module spike_timer import spike_pkg::*; #(
    parameter int AIM_TICKS    = `DEF_AIM_TICKS,
    parameter int SLOW_STEP    = `DEF_SLOW_STEP,
    parameter int FAST_STEP    = `DEF_FAST_STEP,
    parameter int SETTLE_TICKS = `DEF_SETTLE_TICKS
) (
    input  logic   clk,
    input  logic   rst,
    input  phase_t phase,
    input  logic   barrage,
    output logic   step_tick,
    output logic   aim_over,
    output logic   settle_over
);

    localparam int STEP_MAX = (SLOW_STEP > FAST_STEP) ? SLOW_STEP : FAST_STEP;
    localparam int AIM_W    = $clog2(AIM_TICKS + 1);
    localparam int STEP_W   = $clog2(STEP_MAX + 1);
    localparam int SETTLE_W = $clog2(SETTLE_TICKS + 1);

    phase_t              phase_q;
    logic                restart;
    logic                stepping;
    logic [AIM_W-1:0]    aim_cnt;
    logic [AIM_W-1:0]    aim_now;
    logic [STEP_W-1:0]   step_cnt;
    logic [STEP_W-1:0]   step_now;
    logic [STEP_W-1:0]   step_period;
    logic [SETTLE_W-1:0] settle_cnt;
    logic [SETTLE_W-1:0] settle_now;

    // first cycle of any phase sees all counters at zero
    assign restart    = phase != phase_q;
    assign aim_now    = restart ? '0 : aim_cnt;
    assign step_now   = restart ? '0 : step_cnt;
    assign settle_now = restart ? '0 : settle_cnt;

    // barrage spikes move twice as often
    assign step_period = barrage ? STEP_W'(FAST_STEP) : STEP_W'(SLOW_STEP);
    assign stepping    = (phase == AIM) || (phase == FALL);

    ////////////////////
    // pulses
    ////////////////////

    assign aim_over    = (phase == AIM) && (aim_now == AIM_W'(AIM_TICKS - 1));
    assign step_tick   = stepping && (step_now == step_period - 1'b1);
    assign settle_over = (phase == SETTLE) && (settle_now == SETTLE_W'(SETTLE_TICKS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            phase_q    <= IDLE;
            aim_cnt    <= '0;
            step_cnt   <= '0;
            settle_cnt <= '0;
        end else begin
            phase_q    <= phase;
            // each counter only runs in its own phase
            aim_cnt    <= (phase == AIM) ? aim_now + 1'b1 : '0;
            settle_cnt <= (phase == SETTLE) ? settle_now + 1'b1 : '0;
            if (!stepping || step_tick) begin
                step_cnt <= '0;
            end else begin
                step_cnt <= step_now + 1'b1;
            end
        end
    end

endmodule
